/* trans_cache.f */
frame_cache_pkg.sv
beat_fifo.sv
cam_ingest.sv
frame_addr_gen.sv
burst_writer.sv
trans_cache.sv
tb_clock_gen.sv
trans_cache_tb.sv

/* Makefile */
TOP = trans_cache_tb

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f trans_cache.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -F '*** TEST PASSED ***' > /dev/null

clean:
	rm -rf obj_dir

.PHONY: sim clean

/* trans_cache_tb.sv */
// dual camera frame writer testbench
`timescale 1ns/1ps
`default_nettype none

module trans_cache_tb;
    import frame_cache_pkg::*;

    localparam int BURST_LEN    = 8;
    localparam int FRAME_BYTES  = 256;
    localparam int FIFO_DEPTH   = 32;
    localparam int NUM_FRAMES   = 4;
    localparam int BPF          = FRAME_BYTES / (BURST_LEN * 4);  // bursts per frame
    localparam int PIX_CYCLES   = NUM_FRAMES * FRAME_BYTES * 2;   // de runs at about half rate
    localparam int LIMIT        = 4 * PIX_CYCLES + 2000;
    localparam int DRAIN_CYCLES = 1000;

    typedef struct packed {
        addr_t                     addr;
        beat_t [BURST_LEN-1:0]     data;
    } exp_burst_t;

    typedef struct packed {
        aw_chan_t                  aw;
        w_chan_t [BURST_LEN-1:0]   w;
    } seen_burst_t;

    logic                    clk;
    logic                    rst;
    logic [NUM_CAMS-1:0]     cam_vs;
    logic [NUM_CAMS-1:0]     cam_de;
    pixel_t [NUM_CAMS-1:0]   cam_pix;
    logic                    awready;
    logic                    wready;
    aw_chan_t                aw;
    logic                    awvalid;
    w_chan_t                 w;
    logic                    wvalid;
    logic                    frame_ready;

    integer      seed       = 32'h5b63;
    integer      stall_seed = ~32'h5b63;
    int          mismatches = 0;
    int          failures   = 0;
    pixel_t      pix_q [NUM_CAMS][NUM_FRAMES][$];
    seen_burst_t seen_q [$];
    int          cmp_done [NUM_CAMS] = '{default: 0};
    int          coll_done [NUM_CAMS] = '{default: 0};
    int          px_tot [NUM_CAMS] = '{default: 0};
    int          hist0 [NUM_CAMS] = '{default: 0};
    int          hist1 [NUM_CAMS] = '{default: 0};
    int          hist2 [NUM_CAMS] = '{default: 0};
    seen_burst_t cur;
    int          nbeat = 0;
    int          cur_cam = 0;
    int          last_served = 0;
    bit          served_any = 1'b0;
    logic        awvalid_q = 1'b0;

    tb_clock_gen #(.PERIOD(20), .RESET_CYCLES(4)) clock_gen_i (.clk(clk), .rst(rst));

    trans_cache #(
        .BURST_LEN   (BURST_LEN),
        .FRAME_BYTES (FRAME_BYTES),
        .FIFO_DEPTH  (FIFO_DEPTH)
    ) trans_cache_i (
        .clk         (clk),
        .rst         (rst),
        .cam_vs      (cam_vs),
        .cam_de      (cam_de),
        .cam_pix     (cam_pix),
        .awready     (awready),
        .wready      (wready),
        .aw          (aw),
        .awvalid     (awvalid),
        .w           (w),
        .wvalid      (wvalid),
        .frame_ready (frame_ready)
    );

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        if (exp !== act) begin
            mismatches++;
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_beat(input string name, input beat_t exp, input beat_t act);
        if (exp !== act) begin
            mismatches++;
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            mismatches++;
            $display("MISMATCH %s expected %b actual %b", name, exp, act);
        end
    endtask

    function automatic int cam_of(input addr_t a);
        return int'(a) / (2 * FRAME_BYTES);
    endfunction

    // region base plus burst step, first pixel in byte 0
    function automatic exp_burst_t expect_burst(input int cam, input int buffer, input int idx);
        exp_burst_t e;
        int         frame;
        int         b;
        int         base;
        frame  = idx / BPF;
        b      = idx % BPF;
        e.addr = addr_t'((2 * cam + buffer) * FRAME_BYTES + b * BURST_LEN * 4);
        for (int i = 0; i < BURST_LEN; i++) begin
            base = (b * BURST_LEN + i) * 4;
            for (int p = 0; p < 4; p++) begin
                e.data[i][p*8 +: 8] = pix_q[cam][frame][base + p];
            end
        end
        return e;
    endfunction

    // slave model with random stalls
    initial begin
        awready = 1'b0;
        wready  = 1'b0;
        forever begin
            @(negedge clk);
            awready = ($random(stall_seed) & 3) != 0;
            wready  = ($random(stall_seed) & 3) != 0;
        end
    end

    // collect bursts and watch the arbitration
    always @(posedge clk) begin
        int cam;
        int oth;
        for (int c = 0; c < NUM_CAMS; c++) begin
            hist2[c] = hist1[c];
            hist1[c] = hist0[c];
            hist0[c] = px_tot[c];
            px_tot[c] += int'(cam_de[c]);
        end
        if (awvalid && !awvalid_q) begin
            cam = cam_of(aw.addr);
            oth = 1 - cam;
            // hist2 holds the pixels that reached the fifo when the choice was made
            if (served_any && cam == last_served && cam < NUM_CAMS &&
                hist2[oth] / 4 - BURST_LEN * coll_done[oth] >= BURST_LEN) begin
                failures++;
                $display("camera %0d served twice in a row while camera %0d had a burst waiting",
                         cam, oth);
            end
        end
        awvalid_q = awvalid;
        if (awvalid && awready) begin
            cur.aw  = aw;
            cur_cam = cam_of(aw.addr);
            nbeat   = 0;
        end
        if (wvalid && wready) begin
            cur.w[nbeat] = w;
            nbeat++;
            if (nbeat == BURST_LEN) begin
                seen_q.push_back(cur);
                nbeat = 0;
                if (cur_cam < NUM_CAMS) begin
                    coll_done[cur_cam]++;
                    last_served = cur_cam;
                    served_any  = 1'b1;
                end
            end
        end
    end

    // compare each completed burst with the reference
    initial begin
        seen_burst_t s;
        exp_burst_t  e;
        int          cam;
        int          idx;
        string       name;
        forever begin
            @(negedge clk);
            while (seen_q.size() != 0) begin
                s   = seen_q.pop_front();
                cam = cam_of(s.aw.addr);
                if (cam >= NUM_CAMS) begin
                    failures++;
                    $display("burst to address %h lies outside every camera region", s.aw.addr);
                end else if (cmp_done[cam] >= NUM_FRAMES * BPF) begin
                    failures++;
                    $display("camera %0d wrote a burst beyond its last frame", cam);
                end else begin
                    idx  = cmp_done[cam];
                    e    = expect_burst(cam, (idx / BPF) % 2, idx);
                    name = $sformatf("cam%0d frame%0d burst%0d", cam, idx / BPF, idx % BPF);
                    check_addr({name, " addr"}, e.addr, s.aw.addr);
                    check_flag({name, " aw fields"}, 1'b1, s.aw.len == 8'(BURST_LEN - 1) &&
                               s.aw.size == 3'd2 && s.aw.burst == 2'b01);
                    for (int i = 0; i < BURST_LEN; i++) begin
                        check_beat($sformatf("%s beat%0d", name, i), e.data[i], s.w[i].data);
                        check_flag($sformatf("%s last%0d", name, i), i == BURST_LEN - 1,
                                   s.w[i].last);
                        check_flag($sformatf("%s strb%0d", name, i), 1'b1, &s.w[i].strb);
                    end
                    cmp_done[cam]++;
                    check_flag({name, " frame_ready"}, cmp_done[0] >= BPF, frame_ready);
                end
            end
        end
    end

    task automatic wait_drain(input int frames);
        int n;
        n = 0;
        while ((cmp_done[0] < frames * BPF || cmp_done[1] < frames * BPF) && n < DRAIN_CYCLES) begin
            @(negedge clk);
            n++;
        end
        for (int c = 0; c < NUM_CAMS; c++) begin
            if (cmp_done[c] < frames * BPF) begin
                failures++;
                $display("camera %0d has only %0d of %0d bursts written after frame %0d",
                         c, cmp_done[c], frames * BPF, frames - 1);
            end
        end
    endtask

    // stimulus, both cameras stream each frame together
    initial begin
        int     sent [NUM_CAMS];
        pixel_t p;
        cam_vs  = '0;
        cam_de  = '0;
        cam_pix = '0;
        wait (rst === 1'b1);
        for (int f = 0; f < NUM_FRAMES; f++) begin
            @(negedge clk);
            cam_vs = '1;
            repeat (2) @(negedge clk);
            cam_vs = '0;
            repeat (3) @(negedge clk);
            sent = '{default: 0};
            while (sent[0] < FRAME_BYTES || sent[1] < FRAME_BYTES) begin
                for (int c = 0; c < NUM_CAMS; c++) begin
                    cam_de[c] = 1'b0;
                    if (sent[c] < FRAME_BYTES && ($random(seed) & 1) != 0) begin
                        p          = pixel_t'($random(seed));
                        cam_de[c]  = 1'b1;
                        cam_pix[c] = p;
                        pix_q[c][f].push_back(p);
                        sent[c]++;
                    end
                end
                @(negedge clk);
            end
            cam_de = '0;
            wait_drain(f + 1);
        end
        repeat (20) @(negedge clk);
        check_flag("final frame_ready", 1'b1, frame_ready);
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (LIMIT) @(posedge clk);
        $display("timeout after %0d cycles, the run did not finish", LIMIT);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
// testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;  // released between edges
    end

endmodule

`default_nettype wire

/* trans_cache.sv */
// dual camera frame writer
`timescale 1ns/1ps
`default_nettype none

module trans_cache #(
    parameter int BURST_LEN   = 8,
    parameter int FRAME_BYTES = 256,
    parameter int FIFO_DEPTH  = 32
) (
    input  logic                                                     clk,
    input  logic                                                     rst,
    input  logic [frame_cache_pkg::NUM_CAMS-1:0]                     cam_vs,
    input  logic [frame_cache_pkg::NUM_CAMS-1:0]                     cam_de,
    input  frame_cache_pkg::pixel_t [frame_cache_pkg::NUM_CAMS-1:0]  cam_pix,
    input  logic                                                     awready,
    input  logic                                                     wready,
    output frame_cache_pkg::aw_chan_t                                aw,
    output logic                                                     awvalid,
    output frame_cache_pkg::w_chan_t                                 w,
    output logic                                                     wvalid,
    output logic                                                     frame_ready
);
    import frame_cache_pkg::*;

    logic  [NUM_CAMS-1:0] frame_start;
    logic  [NUM_CAMS-1:0] buf_sel;
    logic  [NUM_CAMS-1:0] burst_avail;
    logic  [NUM_CAMS-1:0] pop;
    beat_t [NUM_CAMS-1:0] head;
    addr_t [NUM_CAMS-1:0] cam_addr;
    cam_sel_t             burst_cam;
    logic                 burst_accept;

    for (genvar c = 0; c < NUM_CAMS; c++) begin : g_cam
        cam_ingest #(
            .FIFO_DEPTH (FIFO_DEPTH),
            .BURST_LEN  (BURST_LEN)
        ) u_ingest (
            .clk         (clk),
            .rst         (rst),
            .vs          (cam_vs[c]),
            .de          (cam_de[c]),
            .pix         (cam_pix[c]),
            .pop         (pop[c]),
            .frame_start (frame_start[c]),
            .buf_sel     (buf_sel[c]),
            .burst_avail (burst_avail[c]),
            .head        (head[c])
        );
    end

    frame_addr_gen #(
        .BURST_LEN   (BURST_LEN),
        .FRAME_BYTES (FRAME_BYTES)
    ) u_addr_gen (
        .clk          (clk),
        .rst          (rst),
        .frame_start  (frame_start),
        .buf_sel      (buf_sel),
        .burst_cam    (burst_cam),
        .burst_accept (burst_accept),
        .cam_addr     (cam_addr),
        .frame_ready  (frame_ready)
    );

    burst_writer #(
        .BURST_LEN (BURST_LEN)
    ) u_writer (
        .clk          (clk),
        .rst          (rst),
        .burst_avail  (burst_avail),
        .head         (head),
        .cam_addr     (cam_addr),
        .awready      (awready),
        .wready       (wready),
        .pop          (pop),
        .burst_cam    (burst_cam),
        .burst_accept (burst_accept),
        .aw           (aw),
        .awvalid      (awvalid),
        .w            (w),
        .wvalid       (wvalid)
    );

endmodule

`default_nettype wire

/* burst_writer.sv */
// axi write burst sequencer
`timescale 1ns/1ps
`default_nettype none

module burst_writer #(
    parameter int BURST_LEN = 8
) (
    input  logic                                                     clk,
    input  logic                                                     rst,
    input  logic [frame_cache_pkg::NUM_CAMS-1:0]                     burst_avail,
    input  frame_cache_pkg::beat_t [frame_cache_pkg::NUM_CAMS-1:0]   head,
    input  frame_cache_pkg::addr_t [frame_cache_pkg::NUM_CAMS-1:0]   cam_addr,
    input  logic                                                     awready,
    input  logic                                                     wready,
    output logic [frame_cache_pkg::NUM_CAMS-1:0]                     pop,
    output frame_cache_pkg::cam_sel_t                                burst_cam,
    output logic                                                     burst_accept,
    output frame_cache_pkg::aw_chan_t                                aw,
    output logic                                                     awvalid,
    output frame_cache_pkg::w_chan_t                                 w,
    output logic                                                     wvalid
);
    import frame_cache_pkg::*;

    localparam int CNT_W = (BURST_LEN > 1) ? $clog2(BURST_LEN) : 1;

    typedef enum logic [1:0] {
        IDLE,
        ADDR,
        DATA
    } state_t;

    state_t           state;
    cam_sel_t         last_cam;
    cam_sel_t         pick;
    addr_t            addr_q;
    logic [CNT_W-1:0] beat_cnt;
    logic             w_xfer;

    // other camera first if it has a burst waiting
    assign pick = burst_avail[~last_cam] ? ~last_cam : last_cam;

    assign burst_accept = awvalid && awready;
    assign w_xfer       = wvalid && wready;

    always_comb begin
        aw.addr  = addr_q;
        aw.len   = 8'(BURST_LEN - 1);
        aw.size  = SIZE_4B;
        aw.burst = BURST_INCR;
        w.data   = head[burst_cam];
        w.strb   = '1;
        w.last   = beat_cnt == CNT_W'(BURST_LEN - 1);
    end

    always_comb begin
        pop            = '0;
        pop[burst_cam] = w_xfer;
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && |burst_avail) begin
            addr_q <= cam_addr[pick];  // held until aw transfer
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state     <= IDLE;
            awvalid   <= 1'b0;
            wvalid    <= 1'b0;
            last_cam  <= '1;  // camera 0 goes first
            burst_cam <= '0;
            beat_cnt  <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (|burst_avail) begin
                        burst_cam <= pick;
                        awvalid   <= 1'b1;
                        state     <= ADDR;
                    end
                end
                ADDR: begin
                    if (awready) begin
                        awvalid  <= 1'b0;
                        wvalid   <= 1'b1;
                        beat_cnt <= '0;
                        last_cam <= burst_cam;
                        state    <= DATA;
                    end
                end
                DATA: begin
                    if (wready) begin
                        if (w.last) begin
                            wvalid <= 1'b0;
                            state  <= IDLE;
                        end else begin
                            beat_cnt <= beat_cnt + 1'b1;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* frame_addr_gen.sv */
// frame region address generator
`timescale 1ns/1ps
`default_nettype none

module frame_addr_gen #(
    parameter int BURST_LEN   = 8,
    parameter int FRAME_BYTES = 256
) (
    input  logic                                                     clk,
    input  logic                                                     rst,
    input  logic [frame_cache_pkg::NUM_CAMS-1:0]                     frame_start,
    input  logic [frame_cache_pkg::NUM_CAMS-1:0]                     buf_sel,
    input  frame_cache_pkg::cam_sel_t                                burst_cam,
    input  logic                                                     burst_accept,
    output frame_cache_pkg::addr_t [frame_cache_pkg::NUM_CAMS-1:0]   cam_addr,
    output logic                                                     frame_ready
);
    import frame_cache_pkg::*;

    localparam addr_t STEP      = addr_t'(BURST_LEN * BEAT_W / 8);
    localparam addr_t FRAME_LIM = addr_t'(FRAME_BYTES);

    addr_t [NUM_CAMS-1:0] offset;
    addr_t [NUM_CAMS-1:0] nxt;
    logic  [NUM_CAMS-1:0] hit;
    logic                 wrap0;
    logic                 wrap0_q;

    for (genvar c = 0; c < NUM_CAMS; c++) begin : g_cam
        assign hit[c] = burst_accept && (burst_cam == cam_sel_t'(c));
        assign nxt[c] = offset[c] + STEP;

        always_ff @(posedge clk or negedge rst) begin
            if (!rst) begin
                offset[c] <= '0;
            end else if (frame_start[c]) begin
                offset[c] <= '0;
            end else if (hit[c]) begin
                offset[c] <= (nxt[c] >= FRAME_LIM) ? '0 : nxt[c];
            end
        end

        // region = cam * 2 + buffer
        assign cam_addr[c] = addr_t'((2 * c + int'(buf_sel[c])) * FRAME_BYTES) + offset[c];
    end

    assign wrap0 = hit[0] && !frame_start[0] && (nxt[0] >= FRAME_LIM);

    // sticky once camera 0 has filled a region
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wrap0_q     <= 1'b0;
            frame_ready <= 1'b0;
        end else begin
            wrap0_q     <= wrap0;
            frame_ready <= frame_ready || wrap0_q;
        end
    end

endmodule

`default_nettype wire

/* cam_ingest.sv */
// camera pixel ingest
`timescale 1ns/1ps
`default_nettype none

module cam_ingest #(
    parameter int FIFO_DEPTH = 32,
    parameter int BURST_LEN  = 8
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     vs,
    input  logic                     de,
    input  frame_cache_pkg::pixel_t  pix,
    input  logic                     pop,
    output logic                     frame_start,
    output logic                     buf_sel,
    output logic                     burst_avail,
    output frame_cache_pkg::beat_t   head
);
    import frame_cache_pkg::*;

    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    logic             vs_d;
    logic             vs_rise;
    logic [1:0]       lane;
    beat_t            shift;
    logic             beat_done;
    logic [CNT_W-1:0] count;

    assign vs_rise = vs && !vs_d;

    // frame start and ping-pong select
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            vs_d        <= 1'b0;
            frame_start <= 1'b0;
            buf_sel     <= 1'b1;  // first frame lands in buffer 0
        end else begin
            vs_d        <= vs;
            frame_start <= vs_rise;
            if (vs_rise) begin
                buf_sel <= ~buf_sel;
            end
        end
    end

    // lane count, push one cycle after the last pixel
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            lane      <= '0;
            beat_done <= 1'b0;
        end else if (frame_start) begin
            lane      <= '0;
            beat_done <= 1'b0;
        end else begin
            beat_done <= de && (lane == 2'(PIX_PER_BEAT - 1));
            if (de) begin
                lane <= lane + 1'b1;
            end
        end
    end

    // new pixels enter at the top and move down
    always_ff @(posedge clk) begin
        if (de) begin
            shift <= {pix, shift[BEAT_W-1:PIX_W]};
        end
    end

    beat_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk   (clk),
        .rst   (rst),
        .flush (frame_start),
        .push  (beat_done),
        .din   (shift),
        .pop   (pop),
        .dout  (head),
        .count (count)
    );

    assign burst_avail = count >= CNT_W'(BURST_LEN);

endmodule

`default_nettype wire

/* beat_fifo.sv */
// beat fifo
`timescale 1ns/1ps
`default_nettype none

module beat_fifo #(
    parameter int FIFO_DEPTH = 32
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              flush,
    input  logic                              push,
    input  frame_cache_pkg::beat_t            din,
    input  logic                              pop,
    output frame_cache_pkg::beat_t            dout,
    output logic [$clog2(FIFO_DEPTH+1)-1:0]   count
);
    import frame_cache_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    beat_t            mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             wr_en;
    logic             rd_en;

    assign wr_en = push && (count != CNT_W'(FIFO_DEPTH));  // drop when full
    assign rd_en = pop && (count != '0);
    assign dout  = mem[rd_ptr];  // show-ahead

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(wr_en) - CNT_W'(rd_en);
        end
    end

endmodule

`default_nettype wire

/* frame_cache_pkg.sv */
// frame cache shared types
`default_nettype none

package frame_cache_pkg;

    localparam int PIX_W        = 8;
    localparam int PIX_PER_BEAT = 4;
    localparam int BEAT_W       = PIX_W * PIX_PER_BEAT;
    localparam int ADDR_W       = 24;
    localparam int NUM_CAMS     = 2;

    localparam logic [1:0] BURST_INCR = 2'b01;
    localparam logic [2:0] SIZE_4B    = 3'd2;  // 4-byte beats

    typedef logic [PIX_W-1:0]  pixel_t;
    // first pixel received sits in byte 0
    typedef logic [BEAT_W-1:0] beat_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [$clog2(NUM_CAMS)-1:0] cam_sel_t;

    // write address channel payload
    typedef struct packed {
        addr_t      addr;
        logic [7:0] len;
        logic [2:0] size;
        logic [1:0] burst;
    } aw_chan_t;

    // write data channel payload
    typedef struct packed {
        beat_t                 data;
        logic [BEAT_W/8-1:0]   strb;
        logic                  last;
    } w_chan_t;

endpackage

`default_nettype wire
